//--- hdl/animPkg.sv
package animPkg;

    typedef enum logic [2:0]
    {
        Idle,
        WalkFwd,
        WalkBack,
        Crouch,
        Jump,
        Jab
    } actionT;

    typedef logic [2:0] frameT;

    localparam int CountWidth = 4;
    typedef logic [CountWidth-1:0] countT;

    typedef logic [4:0] spriteT;

    // jump frames are not evenly timed; the launch is short and the peak hangs.
    localparam countT JumpLaunchHold = 4'd3;
    localparam countT JumpPeakHold = 4'd7;
    localparam countT JumpGlideHold = 4'd5;

    function automatic frameT frameCount(input actionT act);
        case (act)
            Idle:     return 3'd5;
            WalkFwd:  return 3'd6;
            WalkBack: return 3'd6;
            Crouch:   return 3'd3;
            Jump:     return 3'd7;
            Jab:      return 3'd3;
            default:  return 3'd1;
        endcase
    endfunction

    // sprite of frame 0 of each action; the frames of an action are consecutive.
    function automatic spriteT spriteBase(input actionT act);
        case (act)
            WalkFwd:  return 5'd1;
            WalkBack: return 5'd7;
            Idle:     return 5'd13;
            Crouch:   return 5'd18;
            Jump:     return 5'd21;
            Jab:      return 5'd28;
            default:  return 5'd13;
        endcase
    endfunction

endpackage

//--- hdl/padPkg.sv
package padPkg;

    localparam int HealthWidth = 8;

    typedef struct packed
    {
        logic up;
        logic back;
        logic down;
        logic forward;
        logic punch;
    } padT;

    typedef struct packed
    {
        logic airborne;
        logic [HealthWidth-1:0] health;
    } statusT;

endpackage

//--- hdl/actionControl.sv
`timescale 1ns/1ps

module actionControl
(
    input  logic            Clk,
    input  logic            rstN,
    input  padPkg::padT     pad,
    input  padPkg::statusT  status,
    input  logic            expired,
    output animPkg::actionT action,
    output animPkg::frameT  frame,
    output logic            restart
);
    import animPkg::*;

    actionT nextAction;
    frameT  nextFrame;
    frameT  lastFrame;
    logic   atLast;
    logic   knockdown;
    logic   walkHeld;

    assign knockdown = (status.health == '0);
    assign lastFrame = frameCount(action) - 3'd1;
    assign atLast = (frame == lastFrame);

    // a walk only continues while its own direction is held.
    assign walkHeld = (action == WalkFwd) ? pad.forward : pad.back;

    always_comb
    begin
        nextAction = action;
        nextFrame = frame;
        if (knockdown)
        begin
            nextAction = Crouch;
            nextFrame = 3'd2;
        end
        else
        begin
            case (action)
                Idle:
                begin
                    if (pad.punch)
                    begin
                        nextAction = Jab;
                        nextFrame = '0;
                    end
                    else if (pad.back)
                    begin
                        nextAction = WalkBack;
                        nextFrame = '0;
                    end
                    else if (pad.forward)
                    begin
                        nextAction = WalkFwd;
                        nextFrame = '0;
                    end
                    else if (pad.down)
                    begin
                        nextAction = Crouch;
                        nextFrame = '0;
                    end
                    else if (pad.up)
                    begin
                        nextAction = Jump;
                        nextFrame = '0;
                    end
                    else if (expired)
                    begin
                        nextFrame = atLast ? 3'd0 : frame + 3'd1;
                    end
                end
                WalkFwd, WalkBack:
                begin
                    if (pad.punch)
                    begin
                        nextAction = Jab;
                        nextFrame = '0;
                    end
                    else if (expired)
                    begin
                        nextFrame = atLast ? 3'd0 : frame + 3'd1;
                    end
                    else if (pad.down)
                    begin
                        nextAction = Crouch;
                        nextFrame = '0;
                    end
                    else if (pad.up)
                    begin
                        nextAction = Jump;
                        nextFrame = '0;
                    end
                    else if (!walkHeld)
                    begin
                        nextAction = Idle;
                        nextFrame = '0;
                    end
                end
                Crouch:
                begin
                    if (expired)
                    begin
                        nextFrame = atLast ? frame : frame + 3'd1;
                    end
                    else if (!pad.down)
                    begin
                        // releasing down unwinds the crouch one frame at a time.
                        if (frame == 3'd0)
                        begin
                            nextAction = Idle;
                        end
                        else
                        begin
                            nextFrame = frame - 3'd1;
                        end
                    end
                end
                Jump, Jab:
                begin
                    if (expired)
                    begin
                        nextAction = atLast ? Idle : action;
                        nextFrame = atLast ? 3'd0 : frame + 3'd1;
                    end
                    else if (action == Jump && !status.airborne)
                    begin
                        nextAction = Idle;
                        nextFrame = '0;
                    end
                end
                default:
                begin
                    nextAction = Idle;
                    nextFrame = '0;
                end
            endcase
        end
    end

    assign restart = knockdown || (nextAction != action) || (nextFrame != frame);

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            action <= Idle;
            frame <= '0;
        end
        else
        begin
            action <= nextAction;
            frame <= nextFrame;
        end
    end

endmodule

//--- hdl/holdTimer.sv
`timescale 1ns/1ps

module holdTimer
#(
    parameter int HoldCycles = 6
)
(
    input  logic            Clk,
    input  logic            rstN,
    input  logic            restart,
    input  animPkg::actionT action,
    input  animPkg::frameT  frame,
    output logic            expired
);
    import animPkg::*;

    countT count;
    countT limit;

    always_comb
    begin
        if (action == Jump)
        begin
            case (frame)
                3'd0:    limit = JumpLaunchHold;
                3'd1:    limit = JumpPeakHold;
                default: limit = JumpGlideHold;
            endcase
        end
        else
        begin
            limit = countT'(HoldCycles);
        end
    end

    // high on the last cycle of the frame, so a frame of limit L lasts L cycles.
    assign expired = (count == limit - 4'd1);

    always_ff @(posedge Clk)
    begin
        if (!rstN)
            count <= '0;
        else if (restart || expired)
            count <= '0;
        else
            count <= count + 4'd1;
    end

endmodule

//--- hdl/spriteIndexer.sv
`timescale 1ns/1ps

module spriteIndexer
(
    input  animPkg::actionT action,
    input  animPkg::frameT  frame,
    output animPkg::spriteT sprite
);
    import animPkg::*;

    spriteT base;
    spriteT offset;

    // sprites are laid out walk forward, walk back, idle, crouch, jump, jab.
    assign base = spriteBase(action);
    assign offset = {2'b00, frame};

    assign sprite = base + offset;

endmodule

//--- hdl/fighterAnimator.sv
`timescale 1ns/1ps

module fighterAnimator
#(
    parameter int HoldCycles = 6
)
(
    input  logic            Clk,
    input  logic            rstN,
    input  padPkg::padT     pad,
    input  padPkg::statusT  status,
    output animPkg::spriteT sprite
);
    import animPkg::*;

    actionT action;
    frameT  frame;
    logic   restart;
    logic   expired;

    actionControl u_control
    (
        .Clk     (Clk),
        .rstN    (rstN),
        .pad     (pad),
        .status  (status),
        .expired (expired),
        .action  (action),
        .frame   (frame),
        .restart (restart)
    );

    holdTimer #(.HoldCycles(HoldCycles)) u_timer
    (
        .Clk     (Clk),
        .rstN    (rstN),
        .restart (restart),
        .action  (action),
        .frame   (frame),
        .expired (expired)
    );

    spriteIndexer u_indexer
    (
        .action (action),
        .frame  (frame),
        .sprite (sprite)
    );

endmodule

//--- tests/tbClock.sv
`timescale 1ns/1ps

module tbClock
(
    output logic Clk
);
    // 20 ns period.
    initial Clk = 1'b0;

    always #10 Clk = ~Clk;

endmodule

//--- tests/animChecker.sv
`timescale 1ns/1ps

module animChecker
#(
    parameter int HoldCycles = 6
)
(
    input  logic            Clk,
    input  logic            rstN,
    input  padPkg::padT     pad,
    input  padPkg::statusT  status,
    input  animPkg::spriteT sprite,
    input  int              testNum,
    input  logic            testDone,
    input  int              directFails,
    output int              errorCount,
    output int              checkCount
);
    import animPkg::*;
    import padPkg::*;

    typedef struct packed
    {
        actionT action;
        frameT  frame;
        countT  count;
    } modelT;

    modelT  model;
    spriteT expected;
    logic   primed = 1'b0;
    int     errors = 0;
    int     checks = 0;
    int     markErrors = 0;
    int     markChecks = 0;
    int     markDirect = 0;

    function automatic modelT nextModel(input modelT cur, input padT p, input statusT s);
        modelT  nxt;
        countT  limit;
        frameT  lastIndex;
        logic   expired;
        logic   lastFrame;
        nxt = cur;
        limit = countT'(HoldCycles);
        if (cur.action == Jump)
            limit = (cur.frame == 3'd0) ? 4'd3 : ((cur.frame == 3'd1) ? 4'd7 : 4'd5);
        case (cur.action)
            Idle:              lastIndex = 3'd4;
            WalkFwd, WalkBack: lastIndex = 3'd5;
            Jump:              lastIndex = 3'd6;
            default:           lastIndex = 3'd2;
        endcase
        expired = (cur.count == limit - 4'd1);
        lastFrame = (cur.frame == lastIndex);
        if (s.health == '0)
        begin
            nxt.action = Crouch;
            nxt.frame = 3'd2;
            nxt.count = '0;
        end
        else
        begin
            case (cur.action)
                Idle:
                    if (p.punch) nxt.action = Jab;
                    else if (p.back) nxt.action = WalkBack;
                    else if (p.forward) nxt.action = WalkFwd;
                    else if (p.down) nxt.action = Crouch;
                    else if (p.up) nxt.action = Jump;
                    else if (expired) nxt.frame = lastFrame ? 3'd0 : cur.frame + 3'd1;
                WalkFwd, WalkBack:
                    if (p.punch) nxt.action = Jab;
                    else if (expired) nxt.frame = lastFrame ? 3'd0 : cur.frame + 3'd1;
                    else if (p.down) nxt.action = Crouch;
                    else if (p.up) nxt.action = Jump;
                    else if (!(cur.action == WalkFwd ? p.forward : p.back))
                        nxt.action = Idle;
                Crouch:
                    if (expired) nxt.frame = lastFrame ? cur.frame : cur.frame + 3'd1;
                    else if (!p.down && cur.frame == 3'd0) nxt.action = Idle;
                    else if (!p.down) nxt.frame = cur.frame - 3'd1;
                Jump, Jab:
                    if (expired && lastFrame) nxt.action = Idle;
                    else if (expired) nxt.frame = cur.frame + 3'd1;
                    else if (cur.action == Jump && !s.airborne) nxt.action = Idle;
                default:
                    nxt.action = Idle;
            endcase
            // every change of action starts the new action at its first frame.
            if (nxt.action != cur.action)
                nxt.frame = '0;
            if (nxt.action != cur.action || nxt.frame != cur.frame || expired)
                nxt.count = '0;
            else
                nxt.count = cur.count + 4'd1;
        end
        return nxt;
    endfunction

    function automatic spriteT modelSprite(input modelT m);
        spriteT base;
        case (m.action)
            WalkFwd:  base = 5'd1;
            WalkBack: base = 5'd7;
            Crouch:   base = 5'd18;
            Jump:     base = 5'd21;
            Jab:      base = 5'd28;
            default:  base = 5'd13;
        endcase
        return base + spriteT'(m.frame);
    endfunction

    always @(posedge Clk)
    begin
        if (!rstN)
            model = '{action: Idle, frame: 3'd0, count: 4'd0};
        else
            model = nextModel(model, pad, status);
        primed = 1'b1;
        if (testDone)
        begin
            $display("test %0d done: %0d checks, %0d mismatches, %0d directed failures",
                testNum, checks - markChecks, errors - markErrors, directFails - markDirect);
            markChecks = checks;
            markErrors = errors;
            markDirect = directFails;
        end
    end

    // the sprite only moves on a rising edge, so the falling edge sees it settled.
    always @(negedge Clk)
    begin
        if (primed)
        begin
            expected = modelSprite(model);
            checks++;
            if (sprite !== expected)
            begin
                errors++;
                $display("error sprite expected 0x%h actual 0x%h at %0t",
                    expected, sprite, $time);
            end
        end
    end

    assign errorCount = errors;
    assign checkCount = checks;

endmodule

//--- tests/fighterAnimatorTb.sv
`timescale 1ns/1ps

module fighterAnimatorTb;
    import animPkg::*;
    import padPkg::*;

    logic   Clk;
    logic   rstN;
    padT    pad;
    statusT status;
    spriteT sprite;
    int     testNum;
    logic   testDone;
    int     directFails;
    int     errorCount;
    int     checkCount;

    tbClock u_clock (.Clk(Clk));

    fighterAnimator #(.HoldCycles(6)) u_dut
    (
        .Clk    (Clk),
        .rstN   (rstN),
        .pad    (pad),
        .status (status),
        .sprite (sprite)
    );

    animChecker #(.HoldCycles(6)) u_check
    (
        .Clk         (Clk),
        .rstN        (rstN),
        .pad         (pad),
        .status      (status),
        .sprite      (sprite),
        .testNum     (testNum),
        .testDone    (testDone),
        .directFails (directFails),
        .errorCount  (errorCount),
        .checkCount  (checkCount)
    );

    // checks the sprite on this and the following falling edges.
    task automatic expectHold(input spriteT value, input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            if (sprite !== value)
            begin
                directFails++;
                $display("error sprite expected 0x%h actual 0x%h at %0t", value, sprite, $time);
            end
            @(negedge Clk);
        end
    endtask

    task automatic waitSprite(input spriteT value, input int limit);
        int waited;
        waited = 0;
        do
        begin
            @(negedge Clk);
            waited++;
        end
        while (sprite !== value && waited < limit);
        if (sprite !== value)
        begin
            directFails++;
            $display("timed out after %0d cycles waiting for sprite %0d", limit, value);
        end
    endtask

    task automatic finishTest(input int num);
        testNum = num;
        testDone = 1'b1;
        @(negedge Clk);
        testDone = 1'b0;
    endtask

    initial
    begin
        rstN = 1'b0;
        pad = '0;
        status = '{airborne: 1'b0, health: 8'd100};
        testNum = 0;
        testDone = 1'b0;
        directFails = 0;
        void'($urandom(32'h834704a9));
        repeat (8) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;
        for (int s = 13; s <= 17; s++)
            expectHold(spriteT'(s), 6);
        expectHold(5'd13, 1);
        finishTest(1);

        pad.forward = 1'b1;
        waitSprite(5'd1, 4);
        for (int s = 1; s <= 6; s++)
            expectHold(spriteT'(s), 6);
        expectHold(5'd1, 1);
        pad = '0;
        pad.back = 1'b1;
        waitSprite(5'd7, 4);
        for (int s = 7; s <= 12; s++)
            expectHold(spriteT'(s), 6);
        expectHold(5'd7, 1);
        pad = '0;
        waitSprite(5'd13, 1);
        finishTest(2);

        pad.down = 1'b1;
        waitSprite(5'd18, 4);
        expectHold(5'd18, 6);
        expectHold(5'd19, 6);
        expectHold(5'd20, 10);
        pad = '0;
        waitSprite(5'd19, 1);
        waitSprite(5'd13, 20);
        pad.punch = 1'b1;
        waitSprite(5'd28, 4);
        pad = '0;
        for (int s = 28; s <= 30; s++)
            expectHold(spriteT'(s), 6);
        expectHold(5'd13, 1);
        pad.forward = 1'b1;
        waitSprite(5'd1, 4);
        expectHold(5'd1, 2);
        pad.punch = 1'b1;
        waitSprite(5'd28, 1);
        pad = '0;
        waitSprite(5'd13, 30);
        finishTest(3);

        pad.up = 1'b1;
        status.airborne = 1'b1;
        waitSprite(5'd21, 4);
        pad = '0;
        expectHold(5'd21, 3);
        expectHold(5'd22, 7);
        for (int s = 23; s <= 27; s++)
            expectHold(spriteT'(s), 5);
        expectHold(5'd13, 1);
        pad.up = 1'b1;
        waitSprite(5'd21, 4);
        pad = '0;
        expectHold(5'd21, 1);
        status.airborne = 1'b0;
        waitSprite(5'd13, 1);
        finishTest(4);

        status.health = '0;
        waitSprite(5'd20, 1);
        expectHold(5'd20, 8);
        status.health = 8'd100;
        waitSprite(5'd13, 20);
        pad.forward = 1'b1;
        waitSprite(5'd1, 4);
        expectHold(5'd1, 3);
        status.health = '0;
        waitSprite(5'd20, 1);
        expectHold(5'd20, 4);
        status.health = 8'd100;
        pad = '0;
        waitSprite(5'd13, 20);
        pad.up = 1'b1;
        status.airborne = 1'b1;
        waitSprite(5'd21, 4);
        pad = '0;
        status.health = '0;
        waitSprite(5'd20, 1);
        status = '{airborne: 1'b0, health: 8'd100};
        waitSprite(5'd13, 20);
        finishTest(5);

        // each button is pressed about a quarter of the time.
        for (int i = 0; i < 3000; i++)
        begin
            pad = 5'($urandom & $urandom);
            status.airborne = ($urandom % 8) == 0;
            status.health = ($urandom % 50 == 0) ? '0 : 8'($urandom % 255 + 1);
            @(negedge Clk);
        end
        pad = '0;
        status = '{airborne: 1'b0, health: 8'd100};
        finishTest(6);

        // the checker compares on the falling edge, so its counts settle by the next rising one.
        @(posedge Clk);
        $display("6 tests, %0d checks, %0d mismatches, %0d directed failures",
            checkCount, errorCount, directFails);
        if (errorCount == 0 && directFails == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- sources.f
hdl/animPkg.sv
hdl/padPkg.sv
hdl/actionControl.sv
hdl/holdTimer.sv
hdl/spriteIndexer.sv
hdl/fighterAnimator.sv
tests/tbClock.sv
tests/animChecker.sv
tests/fighterAnimatorTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module fighterAnimatorTb -Mdir obj_dir -f sources.f

./obj_dir/VfighterAnimatorTb > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation passed"
